//--- Makefile
# Verilator build and run of the ID/EX slice testbench.
TOOL      := verilator
FLAGS     := --binary --timing -j 0 -Wno-fatal
TOP       := idExSlice_tb
FILELIST  := idExSlice.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := FAIL: see errors above

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with $(TOOL) and run $(TOP), log in $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hdl/execUnit.sv
`timescale 1ns/1ps
`include "slice_cfg.svh"

module execUnit import pipePkg::*; (
    input  logic               clk,
    input  logic               arstN,
    input  logic               validE,
    input  logic [`DATA_W-1:0] pcE,
    input  logic [`DATA_W-1:0] srcAE,
    input  logic [`DATA_W-1:0] srcBE,
    input  logic [`DATA_W-1:0] immE,
    input  logic [4:0]         saE,
    input  aluOpT              aluOpE,
    input  logic               aluSrcImmE,
    input  branchT             branchE,
    input  logic [25:0]        jumpTargetE,
    input  logic               regWriteE,
    input  logic               hiWriteE,
    input  logic               loWriteE,
    input  logic               resReady,
    output logic               resValid,
    output logic [`DATA_W-1:0] resData,
    output logic               resWrite,
    output logic               takenE,
    output logic [`DATA_W-1:0] redirectPc
);

    logic [`DATA_W-1:0] opB;
    logic [`DATA_W-1:0] hi;
    logic [`DATA_W-1:0] lo;
    logic [`DATA_W-1:0] pcPlus4;
    logic               accepted;

    // ========================================
    // ALU.
    // ========================================
    assign opB = aluSrcImmE ? immE : srcBE;

    always_comb begin
        case (aluOpE)
            ALU_ADD:    resData = srcAE + opB;
            ALU_SUB:    resData = srcAE - opB;
            ALU_AND:    resData = srcAE & opB;
            ALU_OR:     resData = srcAE | opB;
            ALU_XOR:    resData = srcAE ^ opB;
            ALU_SLT:    resData = {{(`DATA_W-1){1'b0}}, $signed(srcAE) < $signed(opB)};
            ALU_SLL:    resData = opB << saE;   // Shifts act on rt.
            ALU_SRL:    resData = opB >> saE;
            ALU_LUI:    resData = {opB[15:0], 16'h0000};
            ALU_PASSHI: resData = hi;
            ALU_PASSLO: resData = lo;
            default:    resData = '0;
        endcase
    end

    // ========================================
    // Branch and jump resolution.
    // ========================================
    assign pcPlus4 = pcE + `DATA_W'd4;

    always_comb begin
        case (branchE)
            BR_EQ:   takenE = validE & (srcAE == srcBE);
            BR_NE:   takenE = validE & (srcAE != srcBE);
            BR_JUMP: takenE = validE;
            default: takenE = 1'b0;
        endcase
    end

    assign redirectPc = (branchE == BR_JUMP)
                      ? {pcPlus4[`DATA_W-1:28], jumpTargetE, 2'b00}
                      : pcPlus4 + {immE[`DATA_W-3:0], 2'b00};

    assign resValid = validE;
    assign resWrite = validE & regWriteE;
    assign accepted = validE & resReady;

    // HI and LO change only when the MTHI or MTLO result leaves.
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            hi <= '0;
            lo <= '0;
        end else if (accepted) begin
            if (hiWriteE) hi <= srcAE;
            if (loWriteE) lo <= srcAE;
        end
    end

endmodule

//--- hdl/hazardCtrl.sv
`timescale 1ns/1ps
`include "slice_cfg.svh"

module hazardCtrl (
    input  logic [`REG_ADDR_W-1:0] rs,
    input  logic [`REG_ADDR_W-1:0] rt,
    input  logic [`REG_ADDR_W-1:0] destE,
    input  logic                   regWriteE,
    input  logic                   validE,
    input  logic                   resReady,
    input  logic                   takenE,
    input  logic                   instValid,
    output logic                   fwdA,
    output logic                   fwdB,
    output logic                   stallE,
    output logic                   flushE
);

    logic writerE;

    // The E item will have written its register by the time D is loaded.
    assign writerE = validE & regWriteE & (destE != '0);

    assign fwdA = writerE & (rs == destE);
    assign fwdB = writerE & (rt == destE);

    assign stallE = validE & ~resReady;   // Result not taken, so E must hold.

    // A bubble goes in when the D item is squashed by a taken branch or
    // when there is no instruction to load. Never while E is held.
    assign flushE = ~stallE & (takenE | ~instValid);

endmodule

//--- hdl/idExReg.sv
`timescale 1ns/1ps
`include "slice_cfg.svh"

module idExReg import pipePkg::*; (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   stallE,
    input  logic                   flushE,

    input  logic                   validD,
    input  logic [`DATA_W-1:0]     pcD,
    input  logic [`DATA_W-1:0]     srcA,
    input  logic [`DATA_W-1:0]     srcB,
    input  logic [`DATA_W-1:0]     imm,
    input  logic [4:0]             sa,
    input  logic [`REG_ADDR_W-1:0] dest,
    input  aluOpT                  aluOp,
    input  logic                   aluSrcImm,
    input  branchT                 branch,
    input  logic [25:0]            jumpTarget,
    input  logic                   regWrite,
    input  logic                   hiWrite,
    input  logic                   loWrite,

    output logic                   validE,
    output logic [`DATA_W-1:0]     pcE,
    output logic [`DATA_W-1:0]     srcAE,
    output logic [`DATA_W-1:0]     srcBE,
    output logic [`DATA_W-1:0]     immE,
    output logic [4:0]             saE,
    output logic [`REG_ADDR_W-1:0] destE,
    output aluOpT                  aluOpE,
    output logic                   aluSrcImmE,
    output branchT                 branchE,
    output logic [25:0]            jumpTargetE,
    output logic                   regWriteE,
    output logic                   hiWriteE,
    output logic                   loWriteE
);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validE      <= 1'b0;
            pcE         <= `RESET_PC;
            srcAE       <= '0;
            srcBE       <= '0;
            immE        <= '0;
            saE         <= '0;
            destE       <= '0;
            aluOpE      <= ALU_ADD;
            aluSrcImmE  <= 1'b0;
            branchE     <= BR_NONE;
            jumpTargetE <= '0;
            regWriteE   <= 1'b0;
            hiWriteE    <= 1'b0;
            loWriteE    <= 1'b0;
        end else if (flushE) begin   // Bubble.
            validE      <= 1'b0;
            pcE         <= `RESET_PC;
            srcAE       <= '0;
            srcBE       <= '0;
            immE        <= '0;
            saE         <= '0;
            destE       <= '0;
            aluOpE      <= ALU_ADD;
            aluSrcImmE  <= 1'b0;
            branchE     <= BR_NONE;
            jumpTargetE <= '0;
            regWriteE   <= 1'b0;
            hiWriteE    <= 1'b0;
            loWriteE    <= 1'b0;
        end else if (!stallE) begin
            validE      <= validD;
            pcE         <= pcD;
            srcAE       <= srcA;
            srcBE       <= srcB;
            immE        <= imm;
            saE         <= sa;
            destE       <= dest;
            aluOpE      <= aluOp;
            aluSrcImmE  <= aluSrcImm;
            branchE     <= branch;
            jumpTargetE <= jumpTarget;
            regWriteE   <= regWrite;
            hiWriteE    <= hiWrite;
            loWriteE    <= loWrite;
        end
    end

endmodule

//--- hdl/idExSlice.sv
`timescale 1ns/1ps
`include "slice_cfg.svh"

module idExSlice import pipePkg::*; (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   instValid,
    output logic                   instReady,
    input  logic [`DATA_W-1:0]     instWord,
    input  logic [`DATA_W-1:0]     instPc,
    output logic                   resValid,
    input  logic                   resReady,
    output logic [`DATA_W-1:0]     resData,
    output logic [`REG_ADDR_W-1:0] resDest,
    output logic                   resWrite,
    output logic                   redirectValid,
    output logic [`DATA_W-1:0]     redirectPc
);

    // ========================================
    // Decode stage.
    // ========================================
    logic [`REG_ADDR_W-1:0] rsD, rtD, destD;
    logic [`DATA_W-1:0]     immD, rdataA, rdataB, srcAD, srcBD;
    logic [4:0]             saD;
    aluOpT                  aluOpD;
    branchT                 branchD;
    logic [25:0]            jumpTargetD;
    logic                   aluSrcImmD, regWriteD, hiWriteD, loWriteD;
    logic                   fwdA, fwdB, stallE, flushE;

    // ========================================
    // Execute stage.
    // ========================================
    logic                   validE, aluSrcImmE, regWriteE, hiWriteE, loWriteE, takenE;
    logic [`DATA_W-1:0]     pcE, srcAE, srcBE, immE;
    logic [4:0]             saE;
    logic [`REG_ADDR_W-1:0] destE;
    aluOpT                  aluOpE;
    branchT                 branchE;
    logic [25:0]            jumpTargetE;

    regFile uRegFile (
        .clk(clk), .arstN(arstN),
        .raddrA(rsD), .raddrB(rtD), .rdataA(rdataA), .rdataB(rdataB),
        .we(resValid & resReady & resWrite), .waddr(resDest), .wdata(resData)
    );

    instDecoder uDecoder (
        .instWord(instWord), .rs(rsD), .rt(rtD), .dest(destD), .imm(immD), .sa(saD),
        .aluOp(aluOpD), .aluSrcImm(aluSrcImmD), .branch(branchD), .jumpTarget(jumpTargetD),
        .regWrite(regWriteD), .hiWrite(hiWriteD), .loWrite(loWriteD), .illegal()
    );

    hazardCtrl uHazard (
        .rs(rsD), .rt(rtD), .destE(destE), .regWriteE(regWriteE), .validE(validE),
        .resReady(resReady), .takenE(takenE), .instValid(instValid),
        .fwdA(fwdA), .fwdB(fwdB), .stallE(stallE), .flushE(flushE)
    );

    assign srcAD = fwdA ? resData : rdataA;   // Bypass from the E stage.
    assign srcBD = fwdB ? resData : rdataB;

    idExReg uIdEx (
        .clk(clk), .arstN(arstN), .stallE(stallE), .flushE(flushE),
        .validD(instValid), .pcD(instPc), .srcA(srcAD), .srcB(srcBD), .imm(immD), .sa(saD),
        .dest(destD), .aluOp(aluOpD), .aluSrcImm(aluSrcImmD), .branch(branchD),
        .jumpTarget(jumpTargetD), .regWrite(regWriteD), .hiWrite(hiWriteD), .loWrite(loWriteD),
        .validE(validE), .pcE(pcE), .srcAE(srcAE), .srcBE(srcBE), .immE(immE), .saE(saE),
        .destE(destE), .aluOpE(aluOpE), .aluSrcImmE(aluSrcImmE), .branchE(branchE),
        .jumpTargetE(jumpTargetE), .regWriteE(regWriteE), .hiWriteE(hiWriteE),
        .loWriteE(loWriteE)
    );

    execUnit uExec (
        .clk(clk), .arstN(arstN), .validE(validE), .pcE(pcE), .srcAE(srcAE), .srcBE(srcBE),
        .immE(immE), .saE(saE), .aluOpE(aluOpE), .aluSrcImmE(aluSrcImmE), .branchE(branchE),
        .jumpTargetE(jumpTargetE), .regWriteE(regWriteE), .hiWriteE(hiWriteE),
        .loWriteE(loWriteE), .resReady(resReady), .resValid(resValid), .resData(resData),
        .resWrite(resWrite), .takenE(takenE), .redirectPc(redirectPc)
    );

    assign instReady     = ~stallE;
    assign resDest       = destE;
    assign redirectValid = takenE;

endmodule

//--- hdl/instDecoder.sv
`timescale 1ns/1ps
`include "slice_cfg.svh"

module instDecoder import isaPkg::*, pipePkg::*; (
    input  logic [`DATA_W-1:0]     instWord,
    output logic [`REG_ADDR_W-1:0] rs,
    output logic [`REG_ADDR_W-1:0] rt,
    output logic [`REG_ADDR_W-1:0] dest,
    output logic [`DATA_W-1:0]     imm,
    output logic [4:0]             sa,
    output aluOpT                  aluOp,
    output logic                   aluSrcImm,
    output branchT                 branch,
    output logic [25:0]            jumpTarget,
    output logic                   regWrite,
    output logic                   hiWrite,
    output logic                   loWrite,
    output logic                   illegal
);

    opcodeT                 opcode;
    functT                  funct;
    logic [`REG_ADDR_W-1:0] rd;
    logic [15:0]            imm16;
    regDstT                 regDst;
    logic                   zeroExt;
    logic                   regWriteRaw;
    logic                   hiWriteRaw;
    logic                   loWriteRaw;

    // ========================================
    // Field extraction.
    // ========================================
    assign opcode     = opcodeT'(instWord[31:26]);
    assign funct      = functT'(instWord[5:0]);
    assign rs         = instWord[25:21];
    assign rt         = instWord[20:16];
    assign rd         = instWord[15:11];
    assign sa         = instWord[10:6];
    assign imm16      = instWord[15:0];
    assign jumpTarget = instWord[25:0];

    assign imm  = zeroExt ? {{(`DATA_W-16){1'b0}}, imm16} : {{(`DATA_W-16){imm16[15]}}, imm16};
    assign dest = (regDst == DST_RD) ? rd : rt;

    // ========================================
    // Control fields.
    // ========================================
    always_comb begin
        regDst      = DST_RT;
        aluOp       = ALU_ADD;
        aluSrcImm   = 1'b0;
        branch      = BR_NONE;
        zeroExt     = 1'b0;
        regWriteRaw = 1'b0;
        hiWriteRaw  = 1'b0;
        loWriteRaw  = 1'b0;
        illegal     = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                regDst      = DST_RD;
                regWriteRaw = 1'b1;
                case (funct)
                    FN_ADD:  aluOp = ALU_ADD;
                    FN_SUB:  aluOp = ALU_SUB;
                    FN_AND:  aluOp = ALU_AND;
                    FN_OR:   aluOp = ALU_OR;
                    FN_XOR:  aluOp = ALU_XOR;
                    FN_SLT:  aluOp = ALU_SLT;
                    FN_SLL:  aluOp = ALU_SLL;
                    FN_SRL:  aluOp = ALU_SRL;
                    FN_MFHI: aluOp = ALU_PASSHI;
                    FN_MFLO: aluOp = ALU_PASSLO;
                    FN_MTHI: begin
                        regWriteRaw = 1'b0;
                        hiWriteRaw  = 1'b1;   // HI takes rs.
                    end
                    FN_MTLO: begin
                        regWriteRaw = 1'b0;
                        loWriteRaw  = 1'b1;
                    end
                    default: illegal = 1'b1;
                endcase
            end
            OP_ADDI: begin
                aluSrcImm   = 1'b1;
                regWriteRaw = 1'b1;
            end
            OP_ORI: begin
                aluOp       = ALU_OR;
                aluSrcImm   = 1'b1;
                zeroExt     = 1'b1;
                regWriteRaw = 1'b1;
            end
            OP_LUI: begin
                aluOp       = ALU_LUI;
                aluSrcImm   = 1'b1;
                regWriteRaw = 1'b1;
            end
            OP_BEQ:  branch = BR_EQ;
            OP_BNE:  branch = BR_NE;
            OP_J:    branch = BR_JUMP;
            default: illegal = 1'b1;
        endcase
    end

    // An unknown word travels on as a no-op.
    assign regWrite = regWriteRaw & ~illegal;
    assign hiWrite  = hiWriteRaw & ~illegal;
    assign loWrite  = loWriteRaw & ~illegal;

endmodule

//--- hdl/isaPkg.sv
package isaPkg;

    // ========================================
    // Primary opcode field, instWord[31:26].
    // ========================================
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_ORI   = 6'h0d,
        OP_LUI   = 6'h0f
    } opcodeT;

    // ========================================
    // Function field of R-type words, instWord[5:0].
    // ========================================
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_MFHI = 6'h10,
        FN_MTHI = 6'h11,
        FN_MFLO = 6'h12,
        FN_MTLO = 6'h13,
        FN_ADD  = 6'h20,
        FN_SUB  = 6'h22,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a
    } functT;

endpackage

//--- hdl/pipePkg.sv
package pipePkg;

    // Operation performed by the execute stage.
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,   // Zero so that a bubble decodes as ADD.
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLT    = 4'd5,
        ALU_SLL    = 4'd6,
        ALU_SRL    = 4'd7,
        ALU_LUI    = 4'd8,
        ALU_PASSHI = 4'd9,
        ALU_PASSLO = 4'd10
    } aluOpT;

    typedef enum logic [1:0] {
        BR_NONE = 2'd0,
        BR_EQ   = 2'd1,
        BR_NE   = 2'd2,
        BR_JUMP = 2'd3
    } branchT;

    // Which instruction field names the destination register.
    typedef enum logic {
        DST_RT = 1'b0,
        DST_RD = 1'b1
    } regDstT;

endpackage

//--- hdl/regFile.sv
`timescale 1ns/1ps
`include "slice_cfg.svh"

module regFile (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic [`REG_ADDR_W-1:0] raddrA,
    input  logic [`REG_ADDR_W-1:0] raddrB,
    output logic [`DATA_W-1:0]     rdataA,
    output logic [`DATA_W-1:0]     rdataB,
    input  logic                   we,
    input  logic [`REG_ADDR_W-1:0] waddr,
    input  logic [`DATA_W-1:0]     wdata
);

    localparam int NumRegs = 1 << `REG_ADDR_W;

    logic [`DATA_W-1:0] regs [NumRegs];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin   // Register 0 stays zero.
            regs[waddr] <= wdata;
        end
    end

    // Reads see the value before this edge's write.
    assign rdataA = (raddrA == '0) ? '0 : regs[raddrA];
    assign rdataB = (raddrB == '0) ? '0 : regs[raddrB];

endmodule

//--- hdl/slice_cfg.svh
`ifndef SLICE_CFG_SVH
`define SLICE_CFG_SVH

// Datapath width, one machine word.
`define DATA_W 32

// Register number width, 32 architectural registers.
`define REG_ADDR_W 5

// PC carried by a bubble in the ID/EX register.
`define RESET_PC 32'h0000_0000

`endif

//--- idExSlice.f
+incdir+hdl
hdl/isaPkg.sv
hdl/pipePkg.sv
hdl/regFile.sv
hdl/instDecoder.sv
hdl/hazardCtrl.sv
hdl/idExReg.sv
hdl/execUnit.sv
hdl/idExSlice.sv
test/idExSlice_props.sv
test/idExSlice_tb.sv

//--- test/idExSlice_input.txt
# Columns, all hex: pc, instruction word, writes a register, result value,
# redirect taken, redirect target.
00000000 20010005 1 00000005 0 00000000
00000004 2022fffd 1 00000002 0 00000000
00000008 00221820 1 00000007 0 00000000
0000000c 00612022 1 00000002 0 00000000
00000010 34058001 1 00008001 0 00000000
00000014 3c061234 1 12340000 0 00000000
00000018 00c53825 1 12348001 0 00000000
0000001c 00e34024 1 00000001 0 00000000
00000020 00e64826 1 00008001 0 00000000
00000024 00015100 1 00000050 0 00000000
00000028 00075a02 1 00123480 0 00000000
0000002c 200cffff 1 ffffffff 0 00000000
00000030 0181682a 1 00000001 0 00000000
00000034 002c702a 1 00000000 0 00000000
00000038 10640002 0 00000000 0 00000000
0000003c 14640004 0 00000000 1 00000050
00000040 200f0077 0 00000000 0 00000000
00000050 10440003 0 00000000 1 00000060
00000054 200f0099 0 00000000 0 00000000
00000060 08000040 0 00000000 1 00000100
00000064 200f0001 0 00000000 0 00000000
00000100 14210005 0 00000000 0 00000000
00000104 21ef0001 1 00000001 0 00000000
00000108 00e00011 0 00000000 0 00000000
0000010c 01800013 0 00000000 0 00000000
00000110 00008010 1 12348001 0 00000000
00000114 00008812 1 ffffffff 0 00000000
00000118 20200009 1 0000000e 0 00000000
0000011c 00019020 1 00000005 0 00000000

//--- test/idExSlice_props.sv
`timescale 1ns/1ps
`include "slice_cfg.svh"

module idExSlice_props (
    input logic                   clk,
    input logic                   arstN,
    input logic                   instReady,
    input logic                   resValid,
    input logic                   resReady,
    input logic [`DATA_W-1:0]     resData,
    input logic [`REG_ADDR_W-1:0] resDest,
    input logic                   resWrite,
    input logic                   redirectValid
);

    // ========================================
    // Result handshake.
    // ========================================
    resultHeld: assert property (@(posedge clk) disable iff (!arstN)
        resValid && !resReady |=> resValid && $stable(resData) && $stable(resDest)
                                  && $stable(resWrite))
        else $error("Result changed while waiting for resReady.");

    noAcceptUnderStall: assert property (@(posedge clk) disable iff (!arstN)
        resValid && !resReady |-> !instReady)
        else $error("instReady high while the result is stalled.");

    quietAfterReset: assert property (@(posedge clk) !arstN |=> !resValid)
        else $error("resValid high right after reset.");

    // A taken branch squashes the next item, so a bubble follows it.
    bubbleAfterTaken: assert property (@(posedge clk) disable iff (!arstN)
        redirectValid && resReady |=> !resValid)
        else $error("Result present right after an accepted redirect.");

endmodule

bind idExSlice idExSlice_props uProps (
    .clk(clk), .arstN(arstN), .instReady(instReady), .resValid(resValid),
    .resReady(resReady), .resData(resData), .resDest(resDest), .resWrite(resWrite),
    .redirectValid(redirectValid)
);

//--- test/idExSlice_tb.sv
`timescale 1ns/1ps
`include "slice_cfg.svh"

module idExSlice_tb;

    localparam int MaxLines = 64;

    logic                   clk;
    logic                   arstN;
    logic                   instValid;
    logic                   instReady;
    logic [`DATA_W-1:0]     instWord;
    logic [`DATA_W-1:0]     instPc;
    logic                   resValid;
    logic                   resReady;
    logic [`DATA_W-1:0]     resData;
    logic [`REG_ADDR_W-1:0] resDest;
    logic                   resWrite;
    logic                   redirectValid;
    logic [`DATA_W-1:0]     redirectPc;

    logic [31:0] pcArr [MaxLines];
    logic [31:0] wordArr [MaxLines];
    logic [31:0] valArr [MaxLines];
    logic [31:0] tgtArr [MaxLines];
    logic        wrArr [MaxLines];
    logic        redirArr [MaxLines];
    logic        producesArr [MaxLines];   // False for a line squashed by a taken branch.
    int          numLines;
    int          lineIdx;
    int          expIdx;
    int          errors;
    int          checks;
    logic [31:0] lfsr;
    bit          loaded;

    idExSlice i_dut (
        .clk(clk), .arstN(arstN), .instValid(instValid), .instReady(instReady),
        .instWord(instWord), .instPc(instPc), .resValid(resValid), .resReady(resReady),
        .resData(resData), .resDest(resDest), .resWrite(resWrite),
        .redirectValid(redirectValid), .redirectPc(redirectPc)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hb4bc_d35c) : (s >> 1);
    endfunction

    task automatic randomBit(output logic b);
        b    = lfsr[0];
        lfsr = lfsrStep(lfsr);
    endtask

    task automatic compareValue(input logic [31:0] got, input logic [31:0] expected,
                                input string what);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("Fail at %0d ns: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    function automatic int nextProducer(input int from);
        int i;
        i = from;
        while (i < numLines && !producesArr[i]) i++;
        return i;
    endfunction

    // ========================================
    // Stimulus file.
    // ========================================
    task automatic readVectors;
        int          fd;
        int          n;
        string       line;
        logic [31:0] pc, word, wr, val, rd, tgt;
        numLines = 0;
        fd = $fopen("test/idExSlice_input.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the stimulus file test/idExSlice_input.txt.");
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") continue;
            n = $sscanf(line, "%h %h %h %h %h %h", pc, word, wr, val, rd, tgt);
            if (n != 6 || numLines >= MaxLines) begin
                errors++;
                $display("Stimulus line could not be used: %s", line);
                continue;
            end
            pcArr[numLines]    = pc;
            wordArr[numLines]  = word;
            wrArr[numLines]    = wr[0];
            valArr[numLines]   = val;
            redirArr[numLines] = rd[0];
            tgtArr[numLines]   = tgt;
            numLines++;
        end
        $fclose(fd);
        for (int i = 0; i < numLines; i++) begin
            producesArr[i] = (i == 0) || !(producesArr[i-1] && redirArr[i-1]);
        end
    endtask

    // Checks the result that transfers on the coming edge.
    task automatic scoreResult;
        logic [`REG_ADDR_W-1:0] expDest;
        string                  tag;
        if (expIdx >= numLines) begin
            errors++;
            $display("Unexpected result at %0d ns after the last expected one.", $time);
            return;
        end
        tag = $sformatf("pc %h", pcArr[expIdx]);
        // R-type writes rd, the immediate forms write rt.
        expDest = (wordArr[expIdx][31:26] == 6'h00) ? wordArr[expIdx][15:11]
                                                    : wordArr[expIdx][20:16];
        compareValue(resWrite, wrArr[expIdx], {tag, " resWrite"});
        if (wrArr[expIdx]) begin
            compareValue(resData, valArr[expIdx], {tag, " resData"});
            compareValue(resDest, expDest, {tag, " resDest"});
        end
        compareValue(redirectValid, redirArr[expIdx], {tag, " redirectValid"});
        if (redirArr[expIdx]) compareValue(redirectPc, tgtArr[expIdx], {tag, " redirectPc"});
        expIdx = nextProducer(expIdx + 1);
    endtask

    // ========================================
    // Main flow.
    // ========================================
    initial begin : mainFlow
        logic b0;
        logic b1;
        clk       = 1'b0;
        arstN     = 1'b0;
        instValid = 1'b0;
        instWord  = '0;
        instPc    = '0;
        resReady  = 1'b0;
        errors    = 0;
        checks    = 0;
        lineIdx   = 0;
        lfsr      = 32'hbc7a_e132;
        readVectors();
        expIdx = nextProducer(0);
        loaded = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        arstN = 1'b1;
        compareValue(instReady, 1'b1, "instReady after reset");
        while (lineIdx < numLines || expIdx < numLines) begin
            instValid = (lineIdx < numLines);   // Held until accepted.
            if (instValid) begin
                instWord = wordArr[lineIdx];
                instPc   = pcArr[lineIdx];
            end
            randomBit(b0);
            randomBit(b1);
            resReady = b0 | b1;
            @(negedge clk);
            if (resValid && resReady) scoreResult();
            if (instValid && instReady) lineIdx++;
            @(posedge clk);
            #1;
        end
        instValid = 1'b0;
        resReady  = 1'b1;
        repeat (4) begin
            @(negedge clk);
            compareValue(resValid, 1'b0, "resValid after the last result");
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin : watchdog
        int limit;
        wait (loaded);
        limit = numLines * 50 + 100;
        #(limit * 10);
        $display("Timeout: the run did not finish within %0d cycles.", limit);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule
